/* testbench/issueVectors.txt */
# rs1 rs2 rd op fn bsel imm shamt csr pc we wa wd cwe cwa cwd trap cause tpc mret br mstall
# then expected opA opB rdOut opcodeOut stall csrData mode epc, and the tag
0 0 0 0 0 0 0 0 0 0 1 5 1234 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 3 0 wr
5 0 1 1 0 0 0 0 0 0 1 6 abcd 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 rd
7 5 2 1 0 0 0 0 0 0 1 7 55aa 0 0 0 0 0 0 0 0 0 1234 0 1 1 0 0 0 0 wt
0 6 3 1 0 0 0 0 0 0 1 0 ffff 0 0 0 0 0 0 0 0 0 55aa 1234 2 1 0 0 0 0 x0
5 0 8 2 0 1 800 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 abcd 3 1 0 0 0 0 bimm
6 0 9 2 0 2 7 1f 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1234 800 8 2 0 0 0 0 bsh
5 0 a 3 0 1 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 abcd 1f 9 2 0 0 0 0 ld
a 5 b 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1234 4 a 3 1 0 0 0 use
a 5 b 1 0 0 0 0 0 0 1 a 77 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 use2
5 0 0 3 0 1 8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 77 1234 b 1 0 0 0 0 ldx0
0 0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1234 8 0 3 0 0 0 0 rdx0
6 0 c 3 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 ld2
c c d 8 0 1 12345000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 abcd 0 c 3 0 0 0 0 lui
5 6 1 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 12345000 d 8 0 0 0 0 br
6 0 2 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1234 abcd 1 1 0 0 0 0 k1
6 0 3 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 k2
6 5 4 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 kend
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 abcd 1234 4 1 0 0 0 0 ms1
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 abcd 1234 4 1 0 0 0 0 ms2
0 0 6 a 0 0 0 0 340 0 0 0 0 1 340 cafe 0 0 0 0 0 0 abcd 1234 4 1 0 0 0 0 csrw
0 0 7 a 0 0 0 0 342 0 0 0 0 0 0 0 1 b 1000 0 0 0 0 0 6 a 0 cafe 0 0 trap
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 7 a 0 b 3 1000 mret
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1000 done

/* sources.f */
rtl/rvPkg.sv
rtl/csrPkg.sv
rtl/regFile.sv
rtl/hazardScoreboard.sv
rtl/csrFile.sv
rtl/issueStage.sv
testbench/issueStageTb.sv

/* runSim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --assert --top-module issueStageTb -f sources.f -o issueStageSim \
	> sim.log 2>&1 \
	&& ./obj_dir/issueStageSim >> sim.log 2>&1 \
	|| echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0

/* testbench/issueStageTb.sv */
`timescale 1ns/1ps

module issueStageTb;

	localparam int maxVectors = 64;
	// 22 input columns then 8 expected columns
	localparam int vecCols = 30;

	logic clk;
	logic nrst;
	logic [4:0] rs1, rs2, rd, wbAddr, rdOut, shamt;
	rvPkg::opcodeT opcode, opcodeOut;
	rvPkg::bSelT bSel;
	logic [3:0] aluFn, aluFnOut;
	logic [11:0] csrAddr, csrWbAddr, csrAddrOut;
	logic [31:0] imm, pc, wbData, csrWbData, trapCause, trapPc;
	logic [31:0] opA, opB, immOut, pcOut, csrData, epc, trapVector;
	logic wbEn, csrWbEn, trapTaken, mret, branchTaken, memStall, stall;
	csrPkg::modeT currentMode;

	logic [31:0] vecs [maxVectors][vecCols];
	string tags [maxVectors];
	int numVectors = 0;
	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int cycleLimit = 20;

	// Issue register fields and mtvec base that have no vector column
	logic [3:0] expAluFn = '0;
	logic [31:0] expImm = '0;
	logic [31:0] expPc = '0;
	logic [11:0] expCsrAddr = '0;
	logic [31:0] expVector = '0;
	int killLeft = 0;

	issueStage dut0 (.*);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	////////////////////
	// Vector file
	////////////////////

	// Returns the number of tokens found on the line
	function automatic int splitLine(input string line, input int row);
		string tok;
		int n;
		logic [31:0] v;
		n = 0;
		tok = "";
		for (int i = 0; i <= line.len(); i++)
		begin
			if (i == line.len() || line[i] == " " || line[i] == "\t" ||
				line[i] == "\n" || line[i] == "\r")
			begin
				if (tok.len() > 0)
				begin
					if (n < vecCols)
					begin
						void'($sscanf(tok, "%h", v));
						vecs[row][n] = v;
					end
					else if (n == vecCols)
						tags[row] = tok;
					n++;
					tok = "";
				end
			end
			else
				tok = {tok, line.substr(i, i)};
		end
		return n;
	endfunction

	task automatic loadVectors();
		int fd;
		int n;
		string line;
		fd = $fopen("testbench/issueVectors.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("Could not open the vector file testbench/issueVectors.txt");
			return;
		end
		while (!$feof(fd) && numVectors < maxVectors)
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue;
			n = splitLine(line, numVectors);
			if (n == vecCols + 1)
				numVectors++;
			else if (n != 0)
			begin
				errors++;
				$display("Vector line has %0d fields instead of %0d", n, vecCols + 1);
			end
		end
		$fclose(fd);
	endtask

	////////////////////
	// Drive and check
	////////////////////

	task automatic applyVector(input int i);
		rs1 = vecs[i][0][4:0];
		rs2 = vecs[i][1][4:0];
		rd = vecs[i][2][4:0];
		opcode = rvPkg::opcodeT'(vecs[i][3][3:0]);
		aluFn = vecs[i][4][3:0];
		bSel = rvPkg::bSelT'(vecs[i][5][1:0]);
		imm = vecs[i][6];
		shamt = vecs[i][7][4:0];
		csrAddr = vecs[i][8][11:0];
		pc = vecs[i][9];
		wbEn = vecs[i][10][0];
		wbAddr = vecs[i][11][4:0];
		wbData = vecs[i][12];
		csrWbEn = vecs[i][13][0];
		csrWbAddr = vecs[i][14][11:0];
		csrWbData = vecs[i][15];
		trapTaken = vecs[i][16][0];
		trapCause = vecs[i][17];
		trapPc = vecs[i][18];
		mret = vecs[i][19][0];
		branchTaken = vecs[i][20][0];
		memStall = vecs[i][21][0];
	endtask

	// Next rising edge applies hold, then bubble, then capture
	task automatic trackIssue(input int i);
		// Software write to mtvec loses to trap and mret
		if (!vecs[i][16][0] && !vecs[i][19][0] && vecs[i][13][0] &&
			vecs[i][14][11:0] == csrPkg::csrMtvec)
			expVector = {vecs[i][15][31:2], 2'b00};
		if (!vecs[i][21][0])
		begin
			if (killLeft > 0 || vecs[i][26][0])
			begin
				expAluFn = '0;
				expImm = '0;
				expPc = '0;
				expCsrAddr = '0;
			end
			else
			begin
				expAluFn = vecs[i][4][3:0];
				expImm = vecs[i][6];
				expPc = vecs[i][9];
				expCsrAddr = vecs[i][8][11:0];
			end
			if (vecs[i][20][0])
				killLeft = rvPkg::killCycles;
			else if (killLeft > 0)
				killLeft--;
		end
	endtask

	task automatic checkValue(input string tag, input string name,
		input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp)
		else
		begin
			errors++;
			$display("MISMATCH %s %s expected %h actual %h", tag, name, exp, act);
		end
	endtask

	task automatic checkVector(input int i);
		checkValue(tags[i], "opA", vecs[i][22], opA);
		checkValue(tags[i], "opB", vecs[i][23], opB);
		checkValue(tags[i], "rdOut", vecs[i][24], 32'(rdOut));
		checkValue(tags[i], "opcodeOut", vecs[i][25], 32'(opcodeOut));
		checkValue(tags[i], "stall", vecs[i][26], 32'(stall));
		checkValue(tags[i], "csrData", vecs[i][27], csrData);
		checkValue(tags[i], "currentMode", vecs[i][28], 32'(currentMode));
		checkValue(tags[i], "epc", vecs[i][29], epc);
		checkValue(tags[i], "aluFnOut", 32'(expAluFn), 32'(aluFnOut));
		checkValue(tags[i], "immOut", expImm, immOut);
		checkValue(tags[i], "pcOut", expPc, pcOut);
		checkValue(tags[i], "csrAddrOut", 32'(expCsrAddr), 32'(csrAddrOut));
		checkValue(tags[i], "trapVector", expVector, trapVector);
	endtask

	task automatic finishRun();
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	// Watchdog on the whole replay
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycleLimit)
		begin
			errors++;
			$display("Timeout after %0d cycles, the vector replay did not finish", cycles);
			finishRun();
		end
	end

	initial
	begin
		nrst = 1'b0;
		// Row 0 stays all zero when the file cannot be read
		for (int c = 0; c < vecCols; c++)
			vecs[0][c] = '0;
		loadVectors();
		applyVector(0);
		if (numVectors == 0)
		begin
			errors++;
			$display("No stimulus lines were found in the vector file");
		end
		cycleLimit = numVectors + 20;
		repeat (5) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		// Inputs change at the falling edge and outputs settle before the check
		for (int i = 0; i < numVectors; i++)
		begin
			if (i > 0)
				@(negedge clk);
			applyVector(i);
			#10;
			checkVector(i);
			trackIssue(i);
		end
		finishRun();
	end

endmodule

/* rtl/issueStage.sv */
`timescale 1ns/1ps

module issueStage (
	input logic clk,
	input logic nrst,
	// Decode side
	input logic [rvPkg::regAddrW-1:0] rs1,
	input logic [rvPkg::regAddrW-1:0] rs2,
	input logic [rvPkg::regAddrW-1:0] rd,
	input rvPkg::opcodeT opcode,
	input logic [3:0] aluFn,
	input rvPkg::bSelT bSel,
	input logic [rvPkg::xlen-1:0] imm,
	input logic [4:0] shamt,
	input logic [csrPkg::csrAddrW-1:0] csrAddr,
	input logic [rvPkg::xlen-1:0] pc,
	// Commit side
	input logic wbEn,
	input logic [rvPkg::regAddrW-1:0] wbAddr,
	input logic [rvPkg::xlen-1:0] wbData,
	input logic csrWbEn,
	input logic [csrPkg::csrAddrW-1:0] csrWbAddr,
	input logic [rvPkg::xlen-1:0] csrWbData,
	input logic trapTaken,
	input logic [rvPkg::xlen-1:0] trapCause,
	input logic [rvPkg::xlen-1:0] trapPc,
	input logic mret,
	// Control levels
	input logic branchTaken,
	input logic memStall,
	// Execute side
	output logic [rvPkg::xlen-1:0] opA,
	output logic [rvPkg::xlen-1:0] opB,
	output logic [rvPkg::regAddrW-1:0] rdOut,
	output rvPkg::opcodeT opcodeOut,
	output logic [3:0] aluFnOut,
	output logic [rvPkg::xlen-1:0] immOut,
	output logic [rvPkg::xlen-1:0] pcOut,
	output logic [csrPkg::csrAddrW-1:0] csrAddrOut,
	output logic [rvPkg::xlen-1:0] csrData,
	output logic stall,
	output csrPkg::modeT currentMode,
	output logic [rvPkg::xlen-1:0] epc,
	output logic [rvPkg::xlen-1:0] trapVector
);

	logic [rvPkg::xlen-1:0] rfA;
	logic [rvPkg::xlen-1:0] rfB;
	logic kill;

	// Issue register fields not visible as ports
	rvPkg::bSelT bSelQ;
	logic [4:0] shamtQ;
	logic [rvPkg::xlen-1:0] regBQ;

	regFile rf0 (
		.clk(clk),
		.nrst(nrst),
		.wrEn(wbEn),
		.wrAddr(wbAddr),
		.rdAddrA(rs1),
		.rdAddrB(rs2),
		.wrData(wbData),
		.rdDataA(rfA),
		.rdDataB(rfB)
	);

	hazardScoreboard sb0 (
		.clk(clk),
		.nrst(nrst),
		.rs1(rs1),
		.rs2(rs2),
		.opcode(opcode),
		.issueRd(rdOut),
		.issueOpcode(opcodeOut),
		.branchTaken(branchTaken),
		.memStall(memStall),
		.stall(stall),
		.kill(kill)
	);

	csrFile csr0 (
		.clk(clk),
		.nrst(nrst),
		.rdAddr(csrAddrOut),
		.wbAddr(csrWbAddr),
		.wbEn(csrWbEn),
		.trapTaken(trapTaken),
		.mret(mret),
		.wbData(csrWbData),
		.trapCause(trapCause),
		.trapPc(trapPc),
		.rdData(csrData),
		.epc(epc),
		.trapVector(trapVector),
		.currentMode(currentMode)
	);

	//////////////////////
	// Issue register
	//////////////////////

	// Priority is hold, then bubble, then capture
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			opcodeOut <= rvPkg::opNop;
			rdOut <= '0;
			aluFnOut <= '0;
			bSelQ <= rvPkg::bSelReg;
			immOut <= '0;
			shamtQ <= '0;
			csrAddrOut <= '0;
			pcOut <= '0;
			opA <= '0;
			regBQ <= '0;
		end
		else if (!memStall)
		begin
			if (kill || stall)
			begin
				opcodeOut <= rvPkg::opNop;
				rdOut <= '0;
				aluFnOut <= '0;
				bSelQ <= rvPkg::bSelReg;
				immOut <= '0;
				shamtQ <= '0;
				csrAddrOut <= '0;
				pcOut <= '0;
				opA <= '0;
				regBQ <= '0;
			end
			else
			begin
				opcodeOut <= opcode;
				rdOut <= rd;
				aluFnOut <= aluFn;
				bSelQ <= bSel;
				immOut <= imm;
				shamtQ <= shamt;
				csrAddrOut <= csrAddr;
				pcOut <= pc;
				opA <= rfA;
				regBQ <= rfB;
			end
		end
	end

	// Operand B source
	always_comb
	begin
		case (bSelQ)
			rvPkg::bSelImm: opB = immOut;
			rvPkg::bSelShamt: opB = {{(rvPkg::xlen-5){1'b0}}, shamtQ};
			default: opB = regBQ;
		endcase
	end

endmodule

/* rtl/csrFile.sv */
`timescale 1ns/1ps

module csrFile (
	input logic clk,
	input logic nrst,
	input logic [csrPkg::csrAddrW-1:0] rdAddr,
	input logic [csrPkg::csrAddrW-1:0] wbAddr,
	input logic wbEn,
	input logic trapTaken,
	input logic mret,
	input logic [rvPkg::xlen-1:0] wbData,
	input logic [rvPkg::xlen-1:0] trapCause,
	input logic [rvPkg::xlen-1:0] trapPc,
	output logic [rvPkg::xlen-1:0] rdData,
	output logic [rvPkg::xlen-1:0] epc,
	output logic [rvPkg::xlen-1:0] trapVector,
	output csrPkg::modeT currentMode
);

	logic [rvPkg::xlen-1:0] mstatus;
	logic [rvPkg::xlen-1:0] mie;
	logic [rvPkg::xlen-1:0] mtvec;
	logic [rvPkg::xlen-1:0] mscratch;
	logic [rvPkg::xlen-1:0] mepc;
	logic [rvPkg::xlen-1:0] mcause;
	logic [csrPkg::mppW-1:0] mpp;

	assign mpp = mstatus[csrPkg::mppBit +: csrPkg::mppW];

	//////////////////////
	// Register update
	//////////////////////

	// Trap wins over mret, both win over a software write
	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			mstatus <= '0;
			mie <= '0;
			mtvec <= '0;
			mscratch <= '0;
			mepc <= '0;
			mcause <= '0;
			currentMode <= csrPkg::modeMachine;
		end
		else if (trapTaken)
		begin
			mepc <= trapPc;
			mcause <= trapCause;
			mstatus[csrPkg::mppBit +: csrPkg::mppW] <= currentMode;
			currentMode <= csrPkg::modeMachine;
		end
		else if (mret)
		begin
			// Unsupported MPP encodings fall back to user
			currentMode <= (mpp == csrPkg::modeMachine) ? csrPkg::modeMachine : csrPkg::modeUser;
			mstatus[csrPkg::mppBit +: csrPkg::mppW] <= csrPkg::modeUser;
		end
		else if (wbEn)
		begin
			case (wbAddr)
				csrPkg::csrMstatus: mstatus <= wbData;
				csrPkg::csrMie: mie <= wbData;
				csrPkg::csrMtvec: mtvec <= wbData;
				csrPkg::csrMscratch: mscratch <= wbData;
				csrPkg::csrMepc: mepc <= wbData;
				csrPkg::csrMcause: mcause <= wbData;
				default: ;
			endcase
		end
	end

	//////////////////////
	// Read side
	//////////////////////

	always_comb
	begin
		case (rdAddr)
			csrPkg::csrMstatus: rdData = mstatus;
			csrPkg::csrMie: rdData = mie;
			csrPkg::csrMtvec: rdData = mtvec;
			csrPkg::csrMscratch: rdData = mscratch;
			csrPkg::csrMepc: rdData = mepc;
			csrPkg::csrMcause: rdData = mcause;
			default: rdData = '0;
		endcase
	end

	assign epc = mepc;

	// Direct mode only, vector base is word aligned
	assign trapVector = {mtvec[rvPkg::xlen-1:2], 2'b00};

endmodule

/* rtl/hazardScoreboard.sv */
`timescale 1ns/1ps

module hazardScoreboard (
	input logic clk,
	input logic nrst,
	input logic [rvPkg::regAddrW-1:0] rs1,
	input logic [rvPkg::regAddrW-1:0] rs2,
	input rvPkg::opcodeT opcode,
	input logic [rvPkg::regAddrW-1:0] issueRd,
	input rvPkg::opcodeT issueOpcode,
	input logic branchTaken,
	input logic memStall,
	output logic stall,
	output logic kill
);

	logic useRs1;
	logic useRs2;
	logic loadInIssue;
	logic [1:0] killCnt;

	//////////////////////
	// Source usage
	//////////////////////

	always_comb
	begin
		case (opcode)
			rvPkg::opLui, rvPkg::opAuipc, rvPkg::opJal, rvPkg::opNop, rvPkg::opSystem:
			begin
				useRs1 = 1'b0;
				useRs2 = 1'b0;
			end
			rvPkg::opAluImm, rvPkg::opLoad, rvPkg::opJalr, rvPkg::opCsr:
			begin
				useRs1 = 1'b1;
				useRs2 = 1'b0;
			end
			// ALU, store and branch read both
			default:
			begin
				useRs1 = 1'b1;
				useRs2 = 1'b1;
			end
		endcase
	end

	//////////////////////
	// Load-use stall
	//////////////////////

	// A load into x0 never produces a hazard
	assign loadInIssue = (issueOpcode == rvPkg::opLoad) && (issueRd != '0);

	assign stall = loadInIssue && ((useRs1 && (rs1 == issueRd)) || (useRs2 && (rs2 == issueRd)));

	//////////////////////
	// Branch kill
	//////////////////////

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
			killCnt <= 2'd0;
		else if (!memStall)
		begin
			if (branchTaken)
				killCnt <= 2'(rvPkg::killCycles);
			else if (killCnt != 2'd0)
				killCnt <= killCnt - 2'd1;
		end
	end

	assign kill = (killCnt != 2'd0);

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic nrst,
	input logic wrEn,
	input logic [rvPkg::regAddrW-1:0] wrAddr,
	input logic [rvPkg::regAddrW-1:0] rdAddrA,
	input logic [rvPkg::regAddrW-1:0] rdAddrB,
	input logic [rvPkg::xlen-1:0] wrData,
	output logic [rvPkg::xlen-1:0] rdDataA,
	output logic [rvPkg::xlen-1:0] rdDataB
);

	// x0 has no storage
	logic [rvPkg::xlen-1:0] regs [1:31];

	// Same-cycle write is forwarded to the reader
	function automatic logic [rvPkg::xlen-1:0] readPort(input logic [rvPkg::regAddrW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wrEn && (wrAddr == addr))
			return wrData;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wrEn && (wrAddr != '0))
		begin
			regs[wrAddr] <= wrData;
		end
	end

	assign rdDataA = readPort(rdAddrA);
	assign rdDataB = readPort(rdAddrB);

endmodule

/* rtl/csrPkg.sv */
package csrPkg;

	localparam int csrAddrW = 12;

	//////////////////////
	// Machine CSR map
	//////////////////////

	localparam logic [csrAddrW-1:0] csrMstatus = 12'h300;
	localparam logic [csrAddrW-1:0] csrMie = 12'h304;
	localparam logic [csrAddrW-1:0] csrMtvec = 12'h305;
	localparam logic [csrAddrW-1:0] csrMscratch = 12'h340;
	localparam logic [csrAddrW-1:0] csrMepc = 12'h341;
	localparam logic [csrAddrW-1:0] csrMcause = 12'h342;

	// Only user and machine modes exist here
	typedef enum logic [1:0] {
		modeUser = 2'd0,
		modeMachine = 2'd3
	} modeT;

	// MPP field inside mstatus
	localparam int mppBit = 11;
	localparam int mppW = 2;

endpackage

/* rtl/rvPkg.sv */
package rvPkg;

	//////////////////////
	// Pipeline widths
	//////////////////////

	localparam int xlen = 32;
	localparam int regAddrW = 5;

	// Bubbles inserted behind a taken branch
	localparam int killCycles = 2;

	//////////////////////
	// Decoded classes
	//////////////////////

	typedef enum logic [3:0] {
		opNop,
		opAlu,
		opAluImm,
		opLoad,
		opStore,
		opBranch,
		opJal,
		opJalr,
		opLui,
		opAuipc,
		opCsr,
		opSystem
	} opcodeT;

	// Source of the second ALU operand
	typedef enum logic [1:0] {
		bSelReg,
		bSelImm,
		bSelShamt
	} bSelT;

endpackage
